// ==== softmax_exp_sum_vectors.txt ====
# L addr data | C shift | E 8 expected exponents | S expected sum | I 8 inputs
# all values hex fp18 {sign, exp[7:0], man[8:0]}, E and S lead their I line
L 000 10100
L 178 0FD00
L 158 0FF80
L 170 0FD80
L 160 0FF00
L 168 0FF40
L 148 0FFC0
L 150 0FFA0
L 164 0FB00
L 154 0FB80
L 140 0FFE0
L 15C 0F900
L 132 0FF00
L 130 0FD00
L 12A 0FB00
L 138 0FF00
C 00
E 0FD00 0FF80 0FD80 0FF00 10100 0FF40 0FFC0 0FFA0
S 1054C
I 10100 10140 10180 101C0 101F0 10120 10160 101A0
E 0FB00 0FF00 0FB80 10100 0FD80 0FFA0 0FFE0 0F900
S 10500
I 30180 10140 30100 101A0 301E0 10100 10180 30140
C 01
E 0FF00 0FD00 0FB00 10100 0FF00 00000 00000 00000
S 10330
I 30180 10140 30100 101A0 301E0 10100 10180 30140
C 00
E 0FD00 0FF80 0FD80 0FF00 10100 0FF40 0FFC0 0FFA0
S 1054C
I 10100 10140 10180 101C0 101F0 10120 10160 101A0

// ==== softmax_exp_sum.f ====
softmax_pkg.sv
fp_add.sv
vec_buffer.sv
exp_lut.sv
exp_accum.sv
softmax_ctrl.sv
softmax_exp_sum.sv
tb_softmax_exp_sum.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f softmax_exp_sum.f \
    --top-module tb_softmax_exp_sum -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// ==== tb_softmax_exp_sum.sv ====
module tb_softmax_exp_sum;
    import softmax_pkg::*;

    localparam int VEC_LEN = 8;

    // one parsed line of the vectors file
    typedef struct packed {
        logic [7:0]       tag;
        logic [3:0]       cnt;      // values on the line
        logic [7:0][17:0] v;
    } rec_t;

    logic       clk;
    logic       rst_n;
    fp18_t      idata;
    logic       idata_valid;
    cfg_shift_t cfg_shift;
    lut_wr_t    lut_wr;
    fp18_t      odata;
    logic       odata_valid;
    fp18_t      sum;
    logic       sum_valid;
    logic       busy;

    rec_t  recs[$];
    fp18_t exp_q[$];                // expected exponents, in output order
    fp18_t sum_q[$];
    int    errors   = 0;
    int    idle_err = 0;
    int    tests    = 0;
    int    cycles   = 0;
    int    limit    = 0;            // 0 until the vectors are counted
    int    n_elem   = 0;
    int    out_cnt  = 0;
    logic  sum_due  = 1'b0;         // sum_valid must show this cycle

    softmax_exp_sum #(.VEC_LEN(VEC_LEN)) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .idata       (idata),
        .idata_valid (idata_valid),
        .cfg_shift   (cfg_shift),
        .lut_wr      (lut_wr),
        .odata       (odata),
        .odata_valid (odata_valid),
        .sum         (sum),
        .sum_valid   (sum_valid),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers, all drives land 2 units after posedge
    ////////////////////////////////////////////////////////////
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_idle();
        while (busy) step();
    endtask

    task automatic write_lut(input lut_addr_t a, input fp18_t d);
        lut_wr.en   = 1'b1;
        lut_wr.addr = a;
        lut_wr.data = d;
        step();
        lut_wr.en   = 1'b0;
    endtask

    task automatic send_elem(input fp18_t x);
        int gap;
        gap = $urandom % 4;         // idle gap 0..3
        repeat (gap) step();
        while (busy) step();
        idata       = x;
        idata_valid = 1'b1;
        step();
        idata_valid = 1'b0;
    endtask

    // junk pulses while streaming, must all be dropped
    task automatic poke_busy();
        assert (busy) else begin
            $display("time %0t: busy did not rise after the last element", $time);
            errors++;
        end
        while (busy) begin
            idata       = fp18_t'($urandom);
            idata_valid = 1'($urandom % 2);
            step();
        end
        idata_valid = 1'b0;
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [17:0] f [8];
        rec_t        r;
        fd = $fopen("softmax_exp_sum_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open softmax_exp_sum_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;   // blank or comment
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", tag,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                r     = '0;
                r.tag = tag;
                r.cnt = 4'(n - 1);
                for (int i = 0; i < 8; i++) r.v[i] = f[i];
                if (tag == "I") n_elem += n - 1;
                recs.push_back(r);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_record(input rec_t r);
        case (r.tag)
            "L": begin
                wait_idle();
                write_lut(r.v[0][8:0], r.v[1]);
            end
            "C": begin
                wait_idle();            // shift only changes between vectors
                cfg_shift = r.v[0][7:0];
                step();
            end
            "E": for (int k = 0; k < int'(r.cnt); k++) exp_q.push_back(r.v[k]);
            "S": sum_q.push_back(r.v[0]);
            "I": begin
                for (int k = 0; k < int'(r.cnt); k++) send_elem(r.v[k]);
                poke_busy();
            end
            default: begin
                $display("unknown record tag %c in the vectors file", r.tag);
                idle_err++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // output checks, sampled on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic compare_word(input string name, input fp18_t got, input fp18_t want);
        assert (got === want) else begin
            $display("FAIL time %0t %s got %05h expected %05h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_exp();
        assert (busy) else begin
            $display("time %0t: busy low while exponents stream out", $time);
            errors++;
        end
        if (exp_q.size() == 0) begin
            $display("time %0t: odata_valid with no expected exponent left", $time);
            errors++;
        end else begin
            compare_word("odata", odata, exp_q.pop_front());
        end
        out_cnt++;
        if (out_cnt == VEC_LEN) begin
            out_cnt = 0;
            sum_due = 1'b1;             // checked on the next sample
        end
    endtask

    task automatic check_sum();
        assert (!busy) else begin
            $display("time %0t: busy still high when the sum is presented", $time);
            errors++;
        end
        if (sum_q.size() == 0) begin
            $display("time %0t: sum_valid with no expected sum left", $time);
            errors++;
        end else begin
            compare_word("sum", sum, sum_q.pop_front());
        end
        tests++;
        $display("test %0d: vector done, sum %05h, %0d errors so far", tests, sum, errors);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (sum_due) begin
                assert (sum_valid) else begin
                    $display("time %0t: sum_valid missing after the last odata_valid", $time);
                    errors++;
                end
            end else begin
                assert (!sum_valid) else begin
                    $display("time %0t: sum_valid without a finished vector", $time);
                    errors++;
                end
            end
            sum_due = 1'b0;
            if (sum_valid) check_sum();
            if (odata_valid) check_exp();
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h135cc918));          // seeds the generator
        rst_n       = 1'b0;
        idata       = '0;
        idata_valid = 1'b0;
        cfg_shift   = '0;
        lut_wr      = '0;
        read_vectors();
        limit = 20 * n_elem + 600;              // 600 covers the table fill
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        // nothing may move before the first input
        repeat (5) begin
            @(negedge clk);
            assert (!busy && !odata_valid && !sum_valid) else begin
                $display("time %0t: outputs active after reset with no input", $time);
                idle_err++;
            end
        end
        $display("test 0: idle after reset, %0d errors", idle_err);

        step();
        for (int a = 0; a < 512; a++) write_lut(9'(a), '0);
        foreach (recs[i]) run_record(recs[i]);
        wait_idle();
        repeat (4) step();

        $display("%0d tests run, %0d errors, %0d exponents and %0d sums never seen",
                 tests + 1, errors + idle_err, exp_q.size(), sum_q.size());
        if (errors + idle_err == 0 && exp_q.size() == 0 && sum_q.size() == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== softmax_exp_sum.sv ====
module softmax_exp_sum
    import softmax_pkg::*;
#(
    parameter int  VEC_LEN = 8,
    localparam int IDX_W   = $clog2(VEC_LEN)
) (
    input  logic       clk,
    input  logic       rst_n,
    input  fp18_t      idata,
    input  logic       idata_valid,
    input  cfg_shift_t cfg_shift,
    input  lut_wr_t    lut_wr,
    output fp18_t      odata,
    output logic       odata_valid,
    output fp18_t      sum,
    output logic       sum_valid,
    output logic       busy
);

    logic             wr_en;
    logic             rd_en;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    fp18_t            diff;
    logic             diff_valid;

    ////////////////////////////////////////////////////////////
    // ctrl -> buffer -> table -> accumulator
    ////////////////////////////////////////////////////////////
    softmax_ctrl #(.VEC_LEN(VEC_LEN)) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .idata_valid (idata_valid),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .wr_idx      (wr_idx),
        .rd_idx      (rd_idx),
        .busy        (busy),
        .sum_valid   (sum_valid)
    );

    vec_buffer #(.VEC_LEN(VEC_LEN)) u_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .idata      (idata),
        .rd_en      (rd_en),
        .rd_idx     (rd_idx),
        .diff       (diff),
        .diff_valid (diff_valid)
    );

    // table output is the streamed exponent
    exp_lut u_lut (
        .clk        (clk),
        .rst_n      (rst_n),
        .diff       (diff),
        .diff_valid (diff_valid),
        .cfg_shift  (cfg_shift),
        .lut_wr     (lut_wr),
        .exp_val    (odata),
        .exp_valid  (odata_valid)
    );

    exp_accum #(.VEC_LEN(VEC_LEN)) u_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .exp_val   (odata),
        .exp_valid (odata_valid),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

endmodule

// ==== softmax_ctrl.sv ====
module softmax_ctrl
    import softmax_pkg::*;
#(
    parameter int  VEC_LEN = 8,
    localparam int IDX_W   = $clog2(VEC_LEN)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             idata_valid,
    output logic             wr_en,
    output logic             rd_en,
    output logic [IDX_W-1:0] wr_idx,
    output logic [IDX_W-1:0] rd_idx,
    output logic             busy,
    input  logic             sum_valid
);

    seq_state_t       state;
    logic [IDX_W-1:0] wr_ptr;
    logic [IDX_W-1:0] rd_ptr;
    logic             busy_q;
    logic             last_wr;     // final element accepted
    logic             last_rd;     // final element read

    // busy drops on the edge that raises sum_valid
    assign busy    = busy_q && !sum_valid;
    assign wr_en   = idata_valid && !busy;     // pulses while busy are dropped
    assign rd_en   = (state == STREAM);
    assign wr_idx  = wr_ptr;
    assign rd_idx  = rd_ptr;
    assign last_wr = wr_en && (wr_ptr == IDX_W'(VEC_LEN - 1));
    assign last_rd = rd_en && (rd_ptr == IDX_W'(VEC_LEN - 1));

    ////////////////////////////////////////////////////////////
    // phase FSM and pointers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            busy_q <= 1'b0;
        end else begin
            case (state)
                IDLE:    if (wr_en) state <= LOAD;
                LOAD:    if (last_wr) state <= STREAM;
                STREAM:  if (last_rd) state <= IDLE;    // busy stays up until sum
                default: state <= IDLE;
            endcase
            if (wr_en) wr_ptr <= last_wr ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= last_rd ? '0 : rd_ptr + 1'b1;
            if (last_wr)        busy_q <= 1'b1;
            else if (sum_valid) busy_q <= 1'b0;
        end
    end

    // reads only inside the busy window
    a_rd_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> busy);

    a_wr_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(wr_ptr) < VEC_LEN);

endmodule

// ==== exp_accum.sv ====
module exp_accum
    import softmax_pkg::*;
#(
    parameter int  VEC_LEN = 8,
    localparam int CNT_W   = $clog2(VEC_LEN)
) (
    input  logic  clk,
    input  logic  rst_n,
    input  fp18_t exp_val,
    input  logic  exp_valid,
    output fp18_t sum,
    output logic  sum_valid
);

    fp18_t            acc_q;      // running total
    fp18_t            acc_next;
    logic [CNT_W-1:0] cnt_q;      // exponents seen so far
    logic             last_exp;

    fp_add u_acc (
        .a (acc_q),
        .b (exp_val),
        .y (acc_next)
    );

    assign last_exp = exp_valid && (cnt_q == CNT_W'(VEC_LEN - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q     <= '0;
            cnt_q     <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= last_exp;
            if (last_exp) begin
                acc_q <= '0;           // ready for next vector
                cnt_q <= '0;
            end else if (exp_valid) begin
                acc_q <= acc_next;
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // sum held until next vector completes
    always_ff @(posedge clk) begin
        if (last_exp) sum <= acc_next;
    end

endmodule

// ==== exp_lut.sv ====
module exp_lut
    import softmax_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fp18_t      diff,
    input  logic       diff_valid,
    input  cfg_shift_t cfg_shift,
    input  lut_wr_t    lut_wr,
    output fp18_t      exp_val,
    output logic       exp_valid
);

    localparam int LUT_DEPTH = 2 ** $bits(lut_addr_t);

    logic [7:0] man_top;          // top 8 mantissa bits
    logic [7:0] man_sh;
    logic [7:0] mag;              // rounded magnitude
    lut_addr_t  addr_next;
    lut_addr_t  addr_q;
    logic       addr_valid;
    logic       rd_go;            // read actually issued
    fp18_t      lut_mem [LUT_DEPTH];

    ////////////////////////////////////////////////////////////
    // float to table address, exponent is ignored
    ////////////////////////////////////////////////////////////
    assign man_top   = diff[8:1];
    assign man_sh    = man_top >> cfg_shift;
    assign mag       = {1'b0, man_sh[7:1]} + {7'd0, man_sh[0]};   // round on dropped lsb
    assign addr_next = {diff[17], mag};

    always_ff @(posedge clk) begin
        if (diff_valid) addr_q <= addr_next;
    end

    ////////////////////////////////////////////////////////////
    // single-port table, host write wins the port
    ////////////////////////////////////////////////////////////
    assign rd_go = addr_valid && !lut_wr.en;

    always_ff @(posedge clk) begin
        if (lut_wr.en)  lut_mem[lut_wr.addr] <= lut_wr.data;
        else if (rd_go) exp_val <= lut_mem[addr_q];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_valid <= 1'b0;
            exp_valid  <= 1'b0;
        end else begin
            addr_valid <= diff_valid;
            exp_valid  <= rd_go;
        end
    end

    // host must stay off the table while a vector streams
    a_no_wr_on_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !(lut_wr.en && addr_valid));

endmodule

// ==== vec_buffer.sv ====
module vec_buffer
    import softmax_pkg::*;
#(
    parameter int  VEC_LEN = 8,
    localparam int IDX_W   = $clog2(VEC_LEN)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_idx,
    input  fp18_t            idata,
    input  logic             rd_en,
    input  logic [IDX_W-1:0] rd_idx,
    output fp18_t            diff,
    output logic             diff_valid
);

    fp18_t elem_mem [VEC_LEN];   // element store
    fp18_t max_q;                // running maximum
    fp18_t neg_max;
    fp18_t sub_out;

    // x beats y under the max rule
    function automatic logic beats(input fp18_t x, input fp18_t y);
        logic diff_sign;
        diff_sign = x[17] ^ y[17];
        if (diff_sign)
            return !x[17];                  // positive wins over negative
        else if (!x[17])
            return x[16:0] > y[16:0];       // both positive, bigger magnitude
        else
            return x[16:0] < y[16:0];       // both negative, smaller magnitude
    endfunction

    ////////////////////////////////////////////////////////////
    // store and track max
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) elem_mem[wr_idx] <= idata;
    end

    // first element of a vector seeds the max
    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx == '0 || beats(idata, max_q))) max_q <= idata;
    end

    ////////////////////////////////////////////////////////////
    // element minus max, one register
    ////////////////////////////////////////////////////////////
    assign neg_max = {~max_q[17], max_q[16:0]};

    fp_add u_sub (
        .a (elem_mem[rd_idx]),
        .b (neg_max),
        .y (sub_out)
    );

    always_ff @(posedge clk) begin
        if (rd_en) diff <= sub_out;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) diff_valid <= 1'b0;
        else        diff_valid <= rd_en;
    end

endmodule

// ==== fp_add.sv ====
module fp_add
    import softmax_pkg::*;
(
    input  fp18_t a,
    input  fp18_t b,
    output fp18_t y
);

    logic       a_big;         // a has the larger magnitude
    logic       sb;            // sign of larger
    logic       ss;            // sign of smaller
    fp_exp_t    eb;
    fp_exp_t    es;
    fp_exp_t    ediff;
    fp_man_t    mb;
    fp_man_t    ms;
    logic [9:0] ms_al;         // aligned smaller mantissa, bit 9 spare
    logic [9:0] msum;          // raw sum or difference
    logic [3:0] lz;            // leading zeros of a difference

    ////////////////////////////////////////////////////////////
    // order operands by magnitude
    ////////////////////////////////////////////////////////////
    // {exp, man} compares as one unsigned magnitude
    assign a_big = (a[16:0] > b[16:0]);

    always_comb begin
        if (a_big) begin
            sb = a[17];
            eb = a[16:9];
            mb = a[8:0];
            ss = b[17];
            es = b[16:9];
            ms = b[8:0];
        end else begin
            sb = b[17];   // ties land here too
            eb = b[16:9];
            mb = b[8:0];
            ss = a[17];
            es = a[16:9];
            ms = a[8:0];
        end
    end

    assign ediff = eb - es;

    ////////////////////////////////////////////////////////////
    // align, add or subtract, normalize
    ////////////////////////////////////////////////////////////
    always_comb begin
        ms_al = '0;
        msum  = '0;
        lz    = '0;
        y     = '0;
        if (!mb[8] && !ms[8]) begin
            y = '0;                               // 0 + 0
        end else if (!ms[8] || ediff > 8'd8) begin
            y = {sb, eb, mb};                     // smaller one drops out
        end else begin
            ms_al = {1'b0, ms} >> ediff;          // truncating align
            if (sb == ss) begin
                msum = {1'b0, mb} + ms_al;
                if (msum[9]) begin
                    // carry out, one step right
                    y = {sb, eb + 8'd1, msum[9:1]};
                end else begin
                    y = {sb, eb, msum[8:0]};
                end
            end else begin
                msum = {1'b0, mb} - ms_al;        // never negative, mb is larger
                if (msum[8:0] == 9'd0) begin
                    y = '0;                       // exact cancel, clean zero
                end else begin
                    // highest set bit wins
                    for (int i = 0; i < 9; i++) begin
                        if (msum[i]) lz = 4'(8 - i);
                    end
                    y = {sb, eb - fp_exp_t'(lz), fp_man_t'(msum[8:0] << lz)};
                end
            end
        end
    end

endmodule

// ==== softmax_pkg.sv ====
package softmax_pkg;

    ////////////////////////////////////////////////////////////
    // 18-bit float: {sign, 8b exponent, 9b mantissa}
    // mantissa keeps an explicit leading one, msb 0 means zero
    ////////////////////////////////////////////////////////////
    typedef logic [17:0] fp18_t;
    typedef logic [7:0]  fp_exp_t;      // exponent field
    typedef logic [8:0]  fp_man_t;      // mantissa field

    typedef logic [8:0]  lut_addr_t;    // {diff sign, 8b magnitude}
    typedef logic [7:0]  cfg_shift_t;   // mantissa right shift

    // host side table write
    typedef struct packed {
        logic      en;
        lut_addr_t addr;
        fp18_t     data;
    } lut_wr_t;

    // controller phases
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STREAM
    } seq_state_t;

endpackage
